// ==== stdout_cfg.svh ====
`ifndef STDOUT_CFG_SVH
`define STDOUT_CFG_SVH

// debug window bus
`define STDOUT_ADDR_WIDTH 12
`define STDOUT_DATA_WIDTH 32

// cluster size, low address bits pick the core
`define STDOUT_NB_CORES 4

// characters held per bank
`define STDOUT_LINE_DEPTH 16

`endif

// ==== stdout_bus_pkg.sv ====
`default_nettype none

`include "stdout_cfg.svh"

package stdout_bus_pkg;

    typedef logic [`STDOUT_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`STDOUT_DATA_WIDTH-1:0] data_t;

    // at least one bit even for a single core
    typedef logic [((`STDOUT_NB_CORES <= 1) ? 1 : $clog2(`STDOUT_NB_CORES))-1:0] core_id_t;

endpackage

`default_nettype wire

// ==== stdout_line_pkg.sv ====
`default_nettype none

`include "stdout_cfg.svh"

package stdout_line_pkg;

    typedef logic [7:0] char_t;

    typedef logic [$clog2(`STDOUT_LINE_DEPTH)-1:0] line_pos_t;
    typedef logic [$clog2(`STDOUT_LINE_DEPTH):0] line_len_t; // one more bit, full bank fits

    typedef enum logic {
        DRAIN_IDLE,
        DRAIN_SEND
    } drain_state_t;

endpackage

`default_nettype wire

// ==== putchar_char_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface putchar_char_if;

    logic                       valid;
    stdout_bus_pkg::core_id_t   core;
    stdout_line_pkg::char_t     char;
    logic                       eol;   // newline or all-zero word

    modport src (
        output valid,
        output core,
        output char,
        output eol
    );

    modport dst (
        input valid,
        input core,
        input char,
        input eol
    );

endinterface

`default_nettype wire

// ==== line_read_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface line_read_if;

    // buffer side
    logic                       ready;
    stdout_line_pkg::line_len_t len;
    stdout_line_pkg::char_t     rd_data;

    // drain side
    stdout_line_pkg::line_pos_t rd_pos;
    logic                       release_line; // frees the oldest closed bank

    modport buffer (
        output ready,
        output len,
        output rd_data,
        input  rd_pos,
        input  release_line
    );

    modport drain (
        input  ready,
        input  len,
        input  rd_data,
        output rd_pos,
        output release_line
    );

endinterface

`default_nettype wire

// ==== putchar_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "stdout_cfg.svh"

module putchar_decode (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic                  req_i,
    input  wire stdout_bus_pkg::addr_t add_i,
    input  wire stdout_bus_pkg::data_t dat_i,
    putchar_char_if.src                char_o
);

    logic                     valid_q;
    stdout_bus_pkg::core_id_t core_d;
    stdout_bus_pkg::core_id_t core_q;
    stdout_line_pkg::char_t   char_q;
    logic                     eol_d;
    logic                     eol_q;

    // single core has no select bits
    assign core_d = (`STDOUT_NB_CORES > 1) ?
                    add_i[$bits(stdout_bus_pkg::core_id_t)-1:0] : '0;

    assign eol_d = (dat_i[7:0] == 8'd10) || (dat_i == '0);

    always_ff @(posedge clk_i) begin
        if (rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        core_q <= core_d;
        char_q <= dat_i[7:0];
        eol_q  <= eol_d;
    end

    assign char_o.valid = valid_q;
    assign char_o.core  = core_q;
    assign char_o.char  = char_q;
    assign char_o.eol   = eol_q;

endmodule

`default_nettype wire

// ==== line_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "stdout_cfg.svh"

module line_buffer #(
    parameter int unsigned CORE_ID = 0
) (
    input  wire logic   clk_i,
    input  wire logic   rst_ni,
    putchar_char_if.dst char_i,
    line_read_if.buffer rd_o,
    output logic        drop_o
);

    stdout_line_pkg::char_t     mem_q [2][`STDOUT_LINE_DEPTH];
    stdout_line_pkg::line_len_t len_q [2];
    logic [1:0]                 closed_q;
    logic                       fill_bank_q;
    logic                       rd_bank_q;   // oldest closed bank
    logic                       drop_q;

    logic                       hit;
    logic                       wr_bank;
    logic                       avail;
    logic                       wr_en;
    logic                       close_en;
    stdout_line_pkg::line_pos_t fill_pos;
    stdout_line_pkg::line_len_t new_len;

    assign hit = char_i.valid && (char_i.core == stdout_bus_pkg::core_id_t'(CORE_ID));

    // move off a closed fill bank once the other one is free again
    assign wr_bank  = closed_q[fill_bank_q] ? ~fill_bank_q : fill_bank_q;
    assign avail    = !closed_q[wr_bank];
    assign wr_en    = hit && avail;
    assign fill_pos = stdout_line_pkg::line_pos_t'(len_q[wr_bank]);
    assign new_len  = len_q[wr_bank] + stdout_line_pkg::line_len_t'(1);
    assign close_en = char_i.eol ||
                      (new_len == stdout_line_pkg::line_len_t'(`STDOUT_LINE_DEPTH));

    always_ff @(posedge clk_i) begin
        if (rst_ni) begin
            fill_bank_q <= 1'b0;
            rd_bank_q   <= 1'b0;
            closed_q    <= '0;
            len_q[0]    <= '0;
            len_q[1]    <= '0;
            drop_q      <= 1'b0;
        end else begin
            drop_q <= hit && !avail;

            if (rd_o.release_line) begin
                closed_q[rd_bank_q] <= 1'b0;
                len_q[rd_bank_q]    <= '0;
                rd_bank_q           <= ~rd_bank_q;
            end

            // never the bank being released, that one is closed
            if (wr_en) begin
                len_q[wr_bank] <= new_len;
                if (close_en) begin
                    closed_q[wr_bank] <= 1'b1;
                    fill_bank_q       <= ~wr_bank;
                end else begin
                    fill_bank_q <= wr_bank;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem_q[wr_bank][fill_pos] <= char_i.char;
        end
    end

    assign rd_o.ready   = closed_q[rd_bank_q];
    assign rd_o.len     = len_q[rd_bank_q];
    assign rd_o.rd_data = mem_q[rd_bank_q][rd_o.rd_pos];

    assign drop_o = drop_q;

endmodule

`default_nettype wire

// ==== line_drain.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "stdout_cfg.svh"

module line_drain (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    line_read_if.drain                 rd_i [`STDOUT_NB_CORES],
    output logic                       out_valid_o,
    output stdout_bus_pkg::core_id_t   out_core_o,
    output stdout_line_pkg::char_t     out_char_o,
    output logic                       out_last_o
);

    stdout_line_pkg::drain_state_t state_q;
    stdout_bus_pkg::core_id_t      rr_q;    // last core served
    stdout_bus_pkg::core_id_t      sel_q;
    stdout_line_pkg::line_pos_t    pos_q;

    stdout_bus_pkg::core_id_t      pick_core;
    logic                          pick_found;
    logic                          last_pos;
    logic                          release_w;

    logic [`STDOUT_NB_CORES-1:0]   ready_w;
    stdout_line_pkg::line_len_t    len_w  [`STDOUT_NB_CORES];
    stdout_line_pkg::char_t        data_w [`STDOUT_NB_CORES];

    logic                          out_valid_q;
    logic                          out_last_q;
    stdout_bus_pkg::core_id_t      out_core_q;
    stdout_line_pkg::char_t        out_char_q;

    // interface arrays only take constant indices
    for (genvar g = 0; g < `STDOUT_NB_CORES; g++) begin : g_port
        assign ready_w[g]           = rd_i[g].ready;
        assign len_w[g]             = rd_i[g].len;
        assign data_w[g]            = rd_i[g].rd_data;
        assign rd_i[g].rd_pos       = pos_q;
        assign rd_i[g].release_line = release_w && (sel_q == stdout_bus_pkg::core_id_t'(g));
    end

    // first ready core after rr_q, wrapping
    always_comb begin : rr_pick
        int idx;
        pick_found = 1'b0;
        pick_core  = rr_q;
        idx        = 0;
        for (int i = 1; i <= `STDOUT_NB_CORES; i++) begin
            idx = (int'(rr_q) + i) % `STDOUT_NB_CORES;
            if (!pick_found && ready_w[idx]) begin
                pick_found = 1'b1;
                pick_core  = stdout_bus_pkg::core_id_t'(idx);
            end
        end
    end

    assign last_pos  = (stdout_line_pkg::line_len_t'(pos_q) + stdout_line_pkg::line_len_t'(1))
                       == len_w[sel_q];
    assign release_w = (state_q == stdout_line_pkg::DRAIN_SEND) && last_pos;

    always_ff @(posedge clk_i) begin
        if (rst_ni) begin
            state_q     <= stdout_line_pkg::DRAIN_IDLE;
            rr_q        <= stdout_bus_pkg::core_id_t'(`STDOUT_NB_CORES - 1); // core 0 first
            sel_q       <= '0;
            pos_q       <= '0;
            out_valid_q <= 1'b0;
            out_last_q  <= 1'b0;
        end else begin
            out_valid_q <= (state_q == stdout_line_pkg::DRAIN_SEND);
            out_last_q  <= release_w;
            case (state_q)
                stdout_line_pkg::DRAIN_IDLE: begin
                    if (pick_found) begin
                        sel_q   <= pick_core;
                        pos_q   <= '0;
                        state_q <= stdout_line_pkg::DRAIN_SEND;
                    end
                end
                stdout_line_pkg::DRAIN_SEND: begin
                    if (last_pos) begin
                        rr_q    <= sel_q;
                        state_q <= stdout_line_pkg::DRAIN_IDLE;
                    end else begin
                        pos_q <= pos_q + stdout_line_pkg::line_pos_t'(1);
                    end
                end
                default: state_q <= stdout_line_pkg::DRAIN_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        out_core_q <= sel_q;
        out_char_q <= data_w[sel_q];
    end

    assign out_valid_o = out_valid_q;
    assign out_core_o  = out_core_q;
    assign out_char_o  = out_char_q;
    assign out_last_o  = out_last_q;

endmodule

`default_nettype wire

// ==== stdout_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "stdout_cfg.svh"

module stdout_unit (
    input  wire logic                     clk_i,
    input  wire logic                     rst_ni,
    input  wire logic                     req_i,
    input  wire stdout_bus_pkg::addr_t    add_i,
    input  wire stdout_bus_pkg::data_t    dat_i,
    output logic                          out_valid_o,
    output stdout_bus_pkg::core_id_t      out_core_o,
    output stdout_line_pkg::char_t        out_char_o,
    output logic                          out_last_o,
    output logic                          drop_o
);

    logic [`STDOUT_NB_CORES-1:0] drop_w;

    putchar_char_if char_if ();
    line_read_if    rd_if [`STDOUT_NB_CORES] ();

    putchar_decode putchar_decode_i (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .req_i  (req_i),
        .add_i  (add_i),
        .dat_i  (dat_i),
        .char_o (char_if)
    );

    // one line store per core, all listening on the same character
    for (genvar g = 0; g < `STDOUT_NB_CORES; g++) begin : g_line
        line_buffer #(
            .CORE_ID (g)
        ) line_buffer_i (
            .clk_i  (clk_i),
            .rst_ni (rst_ni),
            .char_i (char_if),
            .rd_o   (rd_if[g]),
            .drop_o (drop_w[g])
        );
    end

    line_drain line_drain_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .rd_i        (rd_if),
        .out_valid_o (out_valid_o),
        .out_core_o  (out_core_o),
        .out_char_o  (out_char_o),
        .out_last_o  (out_last_o)
    );

    assign drop_o = |drop_w; // one char per cycle, so one-hot at most

endmodule

`default_nettype wire

// ==== stdout_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "stdout_cfg.svh"

module stdout_checker (
    input  wire logic                     clk_i,
    input  wire logic                     rst_ni,
    input  wire logic                     req_i,
    input  wire stdout_bus_pkg::addr_t    add_i,
    input  wire stdout_bus_pkg::data_t    dat_i,
    input  wire logic                     out_valid_i,
    input  wire stdout_bus_pkg::core_id_t out_core_i,
    input  wire stdout_line_pkg::char_t   out_char_i,
    input  wire logic                     out_last_i,
    input  wire logic                     drop_i,
    output int                            err_cnt_o,
    output int                            chk_cnt_o,
    output int                            line_cnt_o,
    output int                            drop_cnt_o,
    output logic                          idle_o
);

    localparam int NB = `STDOUT_NB_CORES;

    logic [8:0]               ring [NB][64];   // {last, char} of every expected character
    logic [5:0]               head [NB];
    logic [5:0]               tail [NB];
    int                       open_len [NB];
    int                       closed [NB];     // complete lines waiting per core
    int                       pend_chars;
    logic [1:0]               pipe_v;          // writes one and two edges back
    stdout_bus_pkg::core_id_t p_core [2];
    stdout_line_pkg::char_t   p_char [2];
    logic                     p_eol [2];
    logic                     in_line;
    logic                     rst_held = 1'b0; // reset already high at the previous edge
    stdout_bus_pkg::core_id_t cur;
    stdout_bus_pkg::core_id_t c;
    logic                     close_w;
    logic [8:0]               exp_w;
    int                       err_cnt = 0;
    int                       chk_cnt = 0;
    int                       line_cnt = 0;
    int                       drop_cnt = 0;

    always @(posedge clk_i) begin
        if (rst_ni) begin
            if (rst_held && ({out_valid_i, out_last_i, drop_i} !== 3'b000)) begin
                $display("Fail at %0t: {out_valid_o, out_last_o, drop_o} expected 000, got %b",
                         $time, {out_valid_i, out_last_i, drop_i});
                err_cnt++;
            end
            for (int k = 0; k < NB; k++) begin
                head[k]     = '0;
                tail[k]     = '0;
                open_len[k] = 0;
                closed[k]   = 0;
            end
            pend_chars = 0;
            pipe_v     = '0;
            in_line    = 1'b0;
        end else begin
            if (drop_i && !pipe_v[1]) begin
                $display("error at %0t: drop_o pulsed with no write two cycles before", $time);
                err_cnt++;
            end
            if (pipe_v[1] && drop_i) begin
                drop_cnt++;
            end else if (pipe_v[1]) begin
                c = p_core[1];
                open_len[c]++;
                close_w = p_eol[1] || (open_len[c] == `STDOUT_LINE_DEPTH);
                ring[c][tail[c]] = {close_w, p_char[1]};
                tail[c]++;
                pend_chars++;
                if (close_w) begin
                    open_len[c] = 0;
                    closed[c]++;
                end
            end
            pipe_v    = {pipe_v[0], req_i};
            p_core[1] = p_core[0];
            p_char[1] = p_char[0];
            p_eol[1]  = p_eol[0];
            p_core[0] = add_i[$bits(stdout_bus_pkg::core_id_t)-1:0];
            p_char[0] = dat_i[7:0];
            p_eol[0]  = (dat_i[7:0] == 8'd10) || (dat_i == '0);

            if (out_last_i && !out_valid_i) begin
                $display("error at %0t: out_last_o high without out_valid_o", $time);
                err_cnt++;
            end
            if (out_valid_i && !in_line) begin
                if (closed[out_core_i] == 0) begin
                    $display("error at %0t: char %h on core %0d but no line is complete there",
                             $time, out_char_i, out_core_i);
                    err_cnt++;
                end else begin
                    in_line = 1'b1;
                    cur     = out_core_i;
                end
            end else if (out_valid_i && out_core_i !== cur) begin
                $display("Fail at %0t: out_core_o expected %0d, got %0d", $time, cur, out_core_i);
                err_cnt++;
            end
            if (out_valid_i && in_line) begin
                exp_w = ring[cur][head[cur]];
                head[cur]++;
                pend_chars--;
                chk_cnt++;
                if (out_char_i !== exp_w[7:0]) begin
                    $display("Fail at %0t: out_char_o expected %h, got %h", $time, exp_w[7:0],
                             out_char_i);
                    err_cnt++;
                end
                if (out_last_i !== exp_w[8]) begin
                    $display("Fail at %0t: out_last_o expected %b, got %b", $time, exp_w[8],
                             out_last_i);
                    err_cnt++;
                end
                if (exp_w[8]) begin // line done so the drain may switch core
                    closed[cur]--;
                    line_cnt++;
                    in_line = 1'b0;
                end
            end
        end
        rst_held = rst_ni;
        idle_o = (pipe_v == 2'b00) && !in_line && (pend_chars == 0);
    end

    assign err_cnt_o  = err_cnt;
    assign chk_cnt_o  = chk_cnt;
    assign line_cnt_o = line_cnt;
    assign drop_cnt_o = drop_cnt;

endmodule

`default_nettype wire

// ==== tb_stdout_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_stdout_unit;

    localparam int NB_TESTS = 6;
    localparam int GAP_RND  = -1; // 0 to 3 idle cycles
    localparam int TIMEOUT  = 400;

    logic                     clk_i = 1'b0;
    logic                     rst_ni;
    logic                     req_i;
    stdout_bus_pkg::addr_t    add_i;
    stdout_bus_pkg::data_t    dat_i;
    logic                     out_valid_o;
    stdout_bus_pkg::core_id_t out_core_o;
    stdout_line_pkg::char_t   out_char_o;
    logic                     out_last_o;
    logic                     drop_o;
    int                       err_cnt;
    int                       chk_cnt;
    int                       line_cnt;
    int                       drop_cnt;
    logic                     idle;
    logic                     timed_out = 1'b0;

    // one row per write where core -1 holds reset for gap cycles
    int                       row_test [128];
    int                       row_core [128];
    stdout_bus_pkg::data_t    row_data [128];
    int                       row_gap [128];
    int                       nb_rows = 0;
    string                    test_name [NB_TESTS + 1];
    int                       exp_lines [NB_TESTS + 1];
    int                       exp_drops [NB_TESTS + 1];
    int                       tb_err = 0;

    always #4 clk_i = ~clk_i;

    stdout_unit stdout_unit_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_i       (req_i),
        .add_i       (add_i),
        .dat_i       (dat_i),
        .out_valid_o (out_valid_o),
        .out_core_o  (out_core_o),
        .out_char_o  (out_char_o),
        .out_last_o  (out_last_o),
        .drop_o      (drop_o)
    );

    stdout_checker stdout_checker_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_i       (req_i),
        .add_i       (add_i),
        .dat_i       (dat_i),
        .out_valid_i (out_valid_o),
        .out_core_i  (out_core_o),
        .out_char_i  (out_char_o),
        .out_last_i  (out_last_o),
        .drop_i      (drop_o),
        .err_cnt_o   (err_cnt),
        .chk_cnt_o   (chk_cnt),
        .line_cnt_o  (line_cnt),
        .drop_cnt_o  (drop_cnt),
        .idle_o      (idle)
    );

    task automatic add_write(input int t, input int core, input stdout_bus_pkg::data_t data,
                             input int gap);
        row_test[nb_rows] = t;
        row_core[nb_rows] = core;
        row_data[nb_rows] = data;
        row_gap[nb_rows]  = gap;
        nb_rows++;
    endtask

    task automatic add_text(input int t, input int core, input string s, input int gap);
        for (int i = 0; i < s.len(); i++) begin
            add_write(t, core, {24'h0, s[i]}, gap);
        end
    endtask

    task automatic set_test(input int t, input string name, input int lines, input int drops);
        test_name[t] = name;
        exp_lines[t] = lines;
        exp_drops[t] = drops;
    endtask

    task automatic run_test(input int t);
        int err0;
        int line0;
        int drop0;
        int gap;
        int wait_cnt;
        err0  = err_cnt + tb_err;
        line0 = line_cnt;
        drop0 = drop_cnt;
        for (int r = 0; r < nb_rows; r++) begin
            if (row_test[r] == t) begin
                gap = (row_gap[r] == GAP_RND) ? int'($urandom_range(3, 0)) : row_gap[r];
                @(posedge clk_i);
                if (row_core[r] < 0) begin
                    req_i  <= 1'b0;
                    rst_ni <= 1'b1;
                    repeat (gap) @(posedge clk_i);
                    rst_ni <= 1'b0;
                end else begin
                    req_i <= 1'b1;
                    add_i <= stdout_bus_pkg::addr_t'(12'h100 + row_core[r]);
                    dat_i <= row_data[r];
                    repeat (gap) begin
                        @(posedge clk_i);
                        req_i <= 1'b0;
                    end
                end
            end
        end
        @(posedge clk_i);
        req_i <= 1'b0;
        wait_cnt = 0;
        @(negedge clk_i);
        while (!idle && wait_cnt < TIMEOUT) begin
            @(negedge clk_i);
            wait_cnt++;
        end
        if (!idle) begin
            $display("timeout in test %0d: lines still missing after %0d cycles", t, TIMEOUT);
            timed_out = 1'b1;
        end else begin
            if (line_cnt - line0 != exp_lines[t]) begin
                $display("Fail at %0t: out_last_o line count expected %0d, got %0d", $time,
                         exp_lines[t], line_cnt - line0);
                tb_err++;
            end
            if (drop_cnt - drop0 != exp_drops[t]) begin
                $display("Fail at %0t: drop_o pulse count expected %0d, got %0d", $time,
                         exp_drops[t], drop_cnt - drop0);
                tb_err++;
            end
            $display("test %0d %s: %0d errors", t, test_name[t], err_cnt + tb_err - err0);
        end
    endtask

    initial begin : main
        rst_ni = 1'b1;
        req_i  = 1'b0;
        add_i  = '0;
        dat_i  = '0;
        void'($urandom(18));

        set_test(1, "single core hi", 1, 0);
        add_text(1, 0, "hi\n", GAP_RND);
        set_test(2, "zero word ends line", 1, 0);
        add_text(2, 2, "ok", GAP_RND);
        add_write(2, 2, 32'h0, 0);
        set_test(3, "four cores interleaved", 4, 0);
        for (int k = 0; k < 3; k++) begin
            for (int c = 0; c < 4; c++) begin
                add_write(3, c, 32'h5A00_0040 + 16 * c + k, 0); // upper bits ignored
            end
        end
        for (int c = 0; c < 4; c++) begin
            add_write(3, c, 32'd10, 0);
        end
        set_test(4, "full bank splits line", 2, 0);
        add_text(4, 3, "abcdefghijklmnopqrst\n", 0);
        set_test(5, "drop while drain busy", 3, 1);
        add_text(5, 0, "ABCDEFGHIJKLMNOP", 0);
        add_text(5, 1, "\n\n\n", 0);
        set_test(6, "reset mid line", 1, 0);
        add_text(6, 1, "xyz", 0);
        add_write(6, -1, 32'h0, 3);
        add_text(6, 1, "ok\n", GAP_RND);

        repeat (10) @(posedge clk_i);
        rst_ni <= 1'b0;
        for (int t = 1; t <= NB_TESTS && !timed_out; t++) begin
            run_test(t);
        end
        repeat (20) @(negedge clk_i);
        $display("tests %0d, characters checked %0d, errors %0d", NB_TESTS, chk_cnt,
                 err_cnt + tb_err);
        if (!timed_out && err_cnt + tb_err == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
stdout_bus_pkg.sv
stdout_line_pkg.sv
putchar_char_if.sv
line_read_if.sv
putchar_decode.sv
line_buffer.sv
line_drain.sv
stdout_unit.sv
stdout_checker.sv
tb_stdout_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the stdout unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps \
    -f files.f \
    --top-module tb_stdout_unit \
    -o tb_stdout_unit
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_stdout_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi
exit 0
